// ==== Makefile ====
TOP = scheduler_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== sim/scheduler_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scheduler_tb;
  import sched_pkg::*;

  localparam int CORE_COUNT      = 4;
  localparam int SLOT_COUNT      = 4;
  localparam int INTERFACE_COUNT = 2;
  localparam int DATA_WIDTH      = 64;
  localparam int CORE_ID_WIDTH   = 2;
  localparam int SLOT_WIDTH      = 3;
  localparam int DEST_WIDTH      = CORE_ID_WIDTH + SLOT_WIDTH;
  localparam int KEEP_WIDTH      = DATA_WIDTH / 8;
  localparam int SET_WIDTH       = 1 << SLOT_WIDTH;
  localparam int WAIT_LIMIT      = 200;

  logic                                  clk;
  logic                                  rst;
  logic                                  ctrl_valid;
  ctrl_word_t                            ctrl_data;
  logic [CORE_ID_WIDTH-1:0]              ctrl_src;
  logic                                  ctrl_ready;
  logic [CORE_COUNT-1:0]                 income_cores;
  logic [CORE_ID_WIDTH-1:0]              count_core;
  logic [SLOT_WIDTH-1:0]                 slot_count;
  logic [INTERFACE_COUNT*DATA_WIDTH-1:0] rx_data;
  logic [INTERFACE_COUNT*KEEP_WIDTH-1:0] rx_keep;
  logic [INTERFACE_COUNT-1:0]            rx_valid;
  logic [INTERFACE_COUNT-1:0]            rx_last;
  logic [INTERFACE_COUNT-1:0]            rx_ready;
  logic [INTERFACE_COUNT*DATA_WIDTH-1:0] data_m_data;
  logic [INTERFACE_COUNT*KEEP_WIDTH-1:0] data_m_keep;
  logic [INTERFACE_COUNT-1:0]            data_m_valid;
  logic [INTERFACE_COUNT-1:0]            data_m_last;
  logic [INTERFACE_COUNT-1:0]            data_m_ready;
  logic [INTERFACE_COUNT*DEST_WIDTH-1:0] data_m_dest;

  // model pools with bit n set while slot n is free
  logic [SET_WIDTH-1:0] free_set [CORE_COUNT];
  int checks;
  int mismatches;
  int timeouts;
  // packets alternate between interfaces and grants follow packet order
  int next_if;

  rx_scheduler #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT),
    .INTERFACE_COUNT(INTERFACE_COUNT),
    .DATA_WIDTH(DATA_WIDTH)
  ) dut_i (.*);

  always #2 clk = ~clk;

  task automatic expect_true(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      mismatches++;
      $display("Mismatch at %0t ns: %s", $time, what);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t ns: %s", $time, what);
  endtask

  // enabled core with the most free slots and the lowest index on a tie
  function automatic int pick_core();
    int best;
    best = -1;
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (income_cores[c] && (free_set[c] != '0) &&
          (best < 0 || $countones(free_set[c]) > $countones(free_set[best]))) begin
        best = c;
      end
    end
    return best;
  endfunction

  task automatic send_ctrl(input msg_type_t kind, input int core, input int slot);
    ctrl_word_t word;
    bit         accepted;
    // unused fields carry noise
    word = ctrl_word_t'({$urandom, $urandom});
    word[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH] = kind;
    word[SLOT_FIELD_LSB +: SLOT_WIDTH] = SLOT_WIDTH'(slot);
    @(posedge clk);
    ctrl_valid <= 1'b1;
    ctrl_data  <= word;
    ctrl_src   <= CORE_ID_WIDTH'(core);
    accepted = 1'b0;
    for (int t = 0; t < WAIT_LIMIT && !accepted; t++) begin
      @(negedge clk);
      accepted = ctrl_ready;
      @(posedge clk);
    end
    ctrl_valid <= 1'b0;
    if (!accepted) begin
      report_timeout("control message was never accepted");
    end
  endtask

  task automatic wait_ctrl_idle();
    bit idle;
    idle = 1'b0;
    for (int t = 0; t < WAIT_LIMIT && !idle; t++) begin
      @(negedge clk);
      idle = ctrl_ready;
    end
    if (!idle) begin
      report_timeout("ctrl_ready did not return high");
    end
  endtask

  task automatic check_count(input int core);
    @(posedge clk);
    count_core <= CORE_ID_WIDTH'(core);
    @(negedge clk);
    expect_true(int'(slot_count) == $countones(free_set[core]),
                $sformatf("slot_count of core %0d is %0d, model has %0d", core,
                          slot_count, $countones(free_set[core])));
  endtask

  task automatic load_slots(input int core, input int n);
    send_ctrl(MSG_SLOT_LOAD, core, n);
    wait_ctrl_idle();
    free_set[core] = SET_WIDTH'((1 << (n + 1)) - 2);
    check_count(core);
  endtask

  task automatic return_msg(input msg_type_t kind, input int core, input int slot);
    send_ctrl(kind, core, slot);
    wait_ctrl_idle();
    if (kind == MSG_PKT_SENT && slot != 0) begin
      free_set[core][slot] = 1'b1;
    end
    check_count(core);
  endtask

  task automatic send_packet(input int ifc, input int len);
    logic [DATA_WIDTH-1:0] word;
    logic [KEEP_WIDTH-1:0] keep;
    logic [DEST_WIDTH-1:0] dest;
    logic [DEST_WIDTH-1:0] first_dest;
    int                    exp_core;
    int                    core;
    int                    slot;
    bit                    done;
    exp_core = pick_core();
    first_dest = '0;
    for (int w = 0; w < len; w++) begin
      word = {$urandom, $urandom};
      keep = KEEP_WIDTH'($urandom);
      @(posedge clk);
      rx_valid[ifc] <= 1'b1;
      rx_last[ifc]  <= (w == len - 1);
      rx_data[ifc*DATA_WIDTH +: DATA_WIDTH] <= word;
      rx_keep[ifc*KEEP_WIDTH +: KEEP_WIDTH] <= keep;
      data_m_ready[ifc] <= ($urandom_range(0, 3) != 0);
      done = 1'b0;
      for (int t = 0; t < WAIT_LIMIT && !done; t++) begin
        @(negedge clk);
        dest = data_m_dest[ifc*DEST_WIDTH +: DEST_WIDTH];
        if (w > 0) begin
          expect_true(rx_ready[ifc] == data_m_ready[ifc], "rx_ready does not follow data_m_ready");
          expect_true(data_m_valid[ifc], "data_m_valid dropped inside a packet");
          expect_true(dest == first_dest, "data_m_dest changed inside a packet");
        end
        if (data_m_valid[ifc] && data_m_ready[ifc]) begin
          done = 1'b1;
          expect_true(data_m_data[ifc*DATA_WIDTH +: DATA_WIDTH] == word, "data_m_data differs");
          expect_true(data_m_keep[ifc*KEEP_WIDTH +: KEEP_WIDTH] == keep, "data_m_keep differs");
          expect_true(data_m_last[ifc] == (w == len - 1), "data_m_last differs");
          if (w == 0) begin
            first_dest = dest;
            core = int'(dest[DEST_WIDTH-1 -: CORE_ID_WIDTH]);
            slot = int'(dest[SLOT_WIDTH-1:0]);
            expect_true(income_cores[core], $sformatf("disabled core %0d named", core));
            expect_true(core == exp_core,
                        $sformatf("destination core %0d, expected %0d", core, exp_core));
            expect_true(slot != 0 && free_set[core][slot],
                        $sformatf("slot %0d is not free on core %0d", slot, core));
            free_set[core][slot] = 1'b0;
          end
        end else begin
          @(posedge clk);
          data_m_ready[ifc] <= ($urandom_range(0, 3) != 0);
        end
      end
      if (!done) begin
        report_timeout("packet word was never transferred");
      end
    end
    @(posedge clk);
    rx_valid[ifc]     <= 1'b0;
    rx_last[ifc]      <= 1'b0;
    data_m_ready[ifc] <= 1'b1;
  endtask

  // with no destination available the interface stays closed
  task automatic expect_blocked(input int ifc);
    @(posedge clk);
    rx_valid[ifc]     <= 1'b1;
    data_m_ready[ifc] <= 1'b1;
    repeat (20) begin
      @(negedge clk);
      expect_true(!rx_ready[ifc] && !data_m_valid[ifc],
                  $sformatf("interface %0d open without a free slot", ifc));
    end
    @(posedge clk);
    rx_valid[ifc] <= 1'b0;
  endtask

  task automatic drain_pools();
    int guard;
    guard = 0;
    // new income_cores value in place before the model picks
    @(posedge clk);
    while (pick_core() >= 0 && guard < 64) begin
      send_packet(next_if, $urandom_range(1, 4));
      next_if = 1 - next_if;
      guard++;
    end
    expect_blocked(next_if);
  endtask

  initial begin
    int core;
    void'($urandom(32'he1d5aae4));
    clk          = 1'b0;
    rst          = 1'b1;
    ctrl_valid   = 1'b0;
    ctrl_data    = '0;
    ctrl_src     = '0;
    income_cores = '1;
    count_core   = '0;
    rx_data      = '0;
    rx_keep      = '0;
    rx_valid     = '0;
    rx_last      = '0;
    data_m_ready = '1;
    for (int c = 0; c < CORE_COUNT; c++) begin
      free_set[c] = '0;
    end
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    next_if    = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // empty pools after reset
    expect_blocked(0);
    expect_blocked(1);
    for (int c = 0; c < CORE_COUNT; c++) begin
      check_count(c);
    end

    @(posedge clk);
    income_cores <= '0;
    load_slots(0, 3);
    load_slots(0, 2);
    load_slots(1, 4);
    load_slots(2, 3);
    return_msg(MSG_PKT_SENT, 0, 3);
    return_msg(MSG_PKT_SENT, 0, 0);
    return_msg(msg_type_t'(1), 0, 4);
    return_msg(msg_type_t'(9), 1, 5);
    // core 2 keeps its slots but must see no packets
    @(posedge clk);
    income_cores <= 4'b1011;
    drain_pools();

    for (int round = 0; round < 3; round++) begin
      @(posedge clk);
      income_cores <= '0;
      for (int c = 0; c < CORE_COUNT; c++) begin
        load_slots(c, $urandom_range(1, SLOT_COUNT));
      end
      core = $urandom_range(0, CORE_COUNT - 1);
      if (!free_set[core][SLOT_COUNT]) begin
        return_msg(MSG_PKT_SENT, core, SLOT_COUNT);
      end
      @(posedge clk);
      income_cores <= CORE_COUNT'($urandom_range(1, (1 << CORE_COUNT) - 1));
      drain_pools();
    end

    repeat (4) @(posedge clk);
    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #1000000;
    $display("Simulation ran past its time limit");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/sched_pkg.sv
verilog/slot_write_if.sv
verilog/pool_view_if.sv
verilog/ctrl_intake.sv
verilog/slot_pool.sv
verilog/core_select.sv
verilog/port_stamp.sv
verilog/rx_scheduler.sv
sim/scheduler_tb.sv

// ==== verilog/core_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_select #(
  parameter int CORE_COUNT = 4,
  parameter int SLOT_COUNT = 4,
  localparam int CORE_ID_WIDTH = (CORE_COUNT > 1) ? $clog2(CORE_COUNT) : 1,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1)
) (
  input  logic                     clk,
  input  logic                     rst,
  pool_view_if.select              view,
  input  logic [CORE_COUNT-1:0]    income_cores,
  output logic                     offer_valid,
  output logic [CORE_ID_WIDTH-1:0] offer_core,
  output logic [SLOT_WIDTH-1:0]    offer_slot,
  input  logic                     take
);

  logic [CORE_COUNT-1:0]    eligible;
  logic                     best_valid;
  logic [CORE_ID_WIDTH-1:0] best_core;
  logic [SLOT_WIDTH-1:0]    best_count;
  logic                     offer_held;

  // a pool being cleared is not a candidate
  assign eligible = income_cores & view.nonempty & ~view.cleared;

  // strict compare keeps the lowest index on a tie
  always_comb begin
    best_valid = 1'b0;
    best_core  = '0;
    best_count = '0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (eligible[c] && (!best_valid || (view.count[c] > best_count))) begin
        best_valid = 1'b1;
        best_core  = CORE_ID_WIDTH'(c);
        best_count = view.count[c];
      end
    end
  end

  // offer goes low for one cycle after each take
  always_ff @(posedge clk) begin
    if (rst) begin
      offer_held <= 1'b0;
    end else begin
      offer_held <= best_valid && !(offer_valid && take);
    end
  end

  always_ff @(posedge clk) begin
    offer_core <= best_core;
    offer_slot <= view.head[best_core];
  end

  // withdrawn while the offered pool is cleared
  assign offer_valid = offer_held && !view.cleared[offer_core];

  assign view.pop      = offer_valid && take;
  assign view.pop_core = offer_core;

  offer_slot_nonzero_a: assert property (@(posedge clk) disable iff (rst)
    offer_valid |-> (offer_slot != '0));

endmodule

`default_nettype wire

// ==== verilog/ctrl_intake.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_intake #(
  parameter int CORE_COUNT = 4,
  parameter int SLOT_COUNT = 4,
  localparam int CORE_ID_WIDTH = (CORE_COUNT > 1) ? $clog2(CORE_COUNT) : 1,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ctrl_valid,
  input  sched_pkg::ctrl_word_t    ctrl_data,
  input  logic [CORE_ID_WIDTH-1:0] ctrl_src,
  output logic                     ctrl_ready,
  slot_write_if.intake             wr
);
  import sched_pkg::*;

  typedef logic [SLOT_WIDTH-1:0] slot_t;

  loader_state_t            state;
  msg_type_t                msg_type;
  slot_t                    msg_slot;
  slot_t                    load_req;
  slot_t                    load_total;
  slot_t                    fill_slot;
  logic [CORE_ID_WIDTH-1:0] load_core;
  logic                     sent_write;

  assign msg_type = ctrl_data[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH];
  assign msg_slot = ctrl_data[SLOT_FIELD_LSB +: SLOT_WIDTH];
  assign load_req = (msg_slot > slot_t'(SLOT_COUNT)) ? slot_t'(SLOT_COUNT) : msg_slot;

  // slot 0 on a return means nothing to give back
  assign sent_write = ctrl_valid && (msg_type == MSG_PKT_SENT) && (msg_slot != '0);

  assign wr.core = (state == LOADER_IDLE) ? ctrl_src : load_core;

  always_comb begin
    wr.valid   = 1'b0;
    wr.clear   = 1'b0;
    wr.slot    = msg_slot;
    ctrl_ready = 1'b0;
    case (state)
      LOADER_IDLE: begin
        // a return to a full pool waits in the stream
        ctrl_ready = !(sent_write && wr.full);
        wr.valid   = sent_write && !wr.full;
      end
      LOADER_CLEAR: begin
        wr.valid = 1'b1;
        wr.clear = 1'b1;
      end
      default: begin
        wr.valid = 1'b1;
        wr.slot  = fill_slot;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= LOADER_IDLE;
    end else begin
      case (state)
        LOADER_IDLE: begin
          if (ctrl_valid && (msg_type == MSG_SLOT_LOAD)) begin
            state <= LOADER_CLEAR;
          end
        end
        LOADER_CLEAR: begin
          state <= (load_total == '0) ? LOADER_IDLE : LOADER_FILL;
        end
        default: begin
          if (fill_slot == load_total) begin
            state <= LOADER_IDLE;
          end
        end
      endcase
    end
  end

  // load request captured while idle and slots counted up from 1
  always_ff @(posedge clk) begin
    if (state == LOADER_IDLE) begin
      load_core  <= ctrl_src;
      load_total <= load_req;
      fill_slot  <= slot_t'(1);
    end else if (state == LOADER_FILL) begin
      fill_slot <= fill_slot + 1'b1;
    end
  end

  // inserts rely on the pool count seen one module over
  no_write_when_full_a: assert property (@(posedge clk) disable iff (rst)
    (wr.valid && !wr.clear) |-> !wr.full);

endmodule

`default_nettype wire

// ==== verilog/pool_view_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pool_view_if #(
  parameter int CORE_COUNT    = 4,
  parameter int CORE_ID_WIDTH = 2,
  parameter int SLOT_WIDTH    = 3
);

  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] count;
  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] head;
  logic [CORE_COUNT-1:0]                 nonempty;
  // pool being emptied in this cycle
  logic [CORE_COUNT-1:0]                 cleared;
  logic                                  pop;
  logic [CORE_ID_WIDTH-1:0]              pop_core;

  modport pool (output count, head, nonempty, cleared, input pop, pop_core);
  modport select (input count, head, nonempty, cleared, output pop, pop_core);

endinterface

`default_nettype wire

// ==== verilog/port_stamp.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_stamp #(
  parameter int CORE_COUNT      = 4,
  parameter int SLOT_COUNT      = 4,
  parameter int INTERFACE_COUNT = 2,
  localparam int CORE_ID_WIDTH = (CORE_COUNT > 1) ? $clog2(CORE_COUNT) : 1,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int DEST_WIDTH    = CORE_ID_WIDTH + SLOT_WIDTH
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  offer_valid,
  input  logic [CORE_ID_WIDTH-1:0]              offer_core,
  input  logic [SLOT_WIDTH-1:0]                 offer_slot,
  output logic                                  take,
  input  logic [INTERFACE_COUNT-1:0]            rx_valid,
  input  logic [INTERFACE_COUNT-1:0]            rx_last,
  output logic [INTERFACE_COUNT-1:0]            rx_ready,
  output logic [INTERFACE_COUNT-1:0]            data_m_valid,
  input  logic [INTERFACE_COUNT-1:0]            data_m_ready,
  output logic [INTERFACE_COUNT*DEST_WIDTH-1:0] data_m_dest
);

  localparam int IF_WIDTH = (INTERFACE_COUNT > 1) ? $clog2(INTERFACE_COUNT) : 1;

  logic [INTERFACE_COUNT-1:0][DEST_WIDTH-1:0] dest;
  logic [INTERFACE_COUNT-1:0] dest_valid;
  logic [INTERFACE_COUNT-1:0] last_xfer;
  logic [INTERFACE_COUNT-1:0] request;
  logic [INTERFACE_COUNT-1:0] grant;
  logic [IF_WIDTH-1:0]        grant_idx;
  logic [IF_WIDTH-1:0]        last_grant;

  assign last_xfer = rx_valid & rx_last & rx_ready;
  assign request   = ~dest_valid | last_xfer;
  assign take      = offer_valid && (request != '0);

  // round robin search starting after the last winner
  always_comb begin
    int idx;
    grant     = '0;
    grant_idx = last_grant;
    for (int k = 1; k <= INTERFACE_COUNT; k++) begin
      idx = (int'(last_grant) + k) % INTERFACE_COUNT;
      if (request[idx] && (grant == '0)) begin
        grant[idx] = 1'b1;
        grant_idx  = IF_WIDTH'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dest_valid <= '0;
      last_grant <= IF_WIDTH'(INTERFACE_COUNT - 1);
    end else begin
      dest_valid <= (dest_valid & ~last_xfer) | (grant & {INTERFACE_COUNT{take}});
      if (take) begin
        last_grant <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      dest[grant_idx] <= {offer_core, offer_slot};
    end
  end

  // without a destination neither direction moves
  assign data_m_valid = rx_valid & dest_valid;
  assign rx_ready     = data_m_ready & dest_valid;
  assign data_m_dest  = dest;

  for (genvar i = 0; i < INTERFACE_COUNT; i++) begin : g_check
    dest_hold_a: assert property (@(posedge clk) disable iff (rst)
      (data_m_valid[i] && !data_m_ready[i]) |=> $stable(dest[i]));
  end

endmodule

`default_nettype wire

// ==== verilog/rx_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_scheduler #(
  parameter int CORE_COUNT      = 4,
  parameter int SLOT_COUNT      = 4,
  parameter int INTERFACE_COUNT = 2,
  parameter int DATA_WIDTH      = 64,
  localparam int CORE_ID_WIDTH = (CORE_COUNT > 1) ? $clog2(CORE_COUNT) : 1,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int DEST_WIDTH    = CORE_ID_WIDTH + SLOT_WIDTH,
  localparam int KEEP_WIDTH    = DATA_WIDTH / 8
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  ctrl_valid,
  input  sched_pkg::ctrl_word_t                 ctrl_data,
  input  logic [CORE_ID_WIDTH-1:0]              ctrl_src,
  output logic                                  ctrl_ready,
  input  logic [CORE_COUNT-1:0]                 income_cores,
  input  logic [CORE_ID_WIDTH-1:0]              count_core,
  output logic [SLOT_WIDTH-1:0]                 slot_count,
  input  logic [INTERFACE_COUNT*DATA_WIDTH-1:0] rx_data,
  input  logic [INTERFACE_COUNT*KEEP_WIDTH-1:0] rx_keep,
  input  logic [INTERFACE_COUNT-1:0]            rx_valid,
  input  logic [INTERFACE_COUNT-1:0]            rx_last,
  output logic [INTERFACE_COUNT-1:0]            rx_ready,
  output logic [INTERFACE_COUNT*DATA_WIDTH-1:0] data_m_data,
  output logic [INTERFACE_COUNT*KEEP_WIDTH-1:0] data_m_keep,
  output logic [INTERFACE_COUNT-1:0]            data_m_valid,
  output logic [INTERFACE_COUNT-1:0]            data_m_last,
  input  logic [INTERFACE_COUNT-1:0]            data_m_ready,
  output logic [INTERFACE_COUNT*DEST_WIDTH-1:0] data_m_dest
);

  logic                     offer_valid;
  logic [CORE_ID_WIDTH-1:0] offer_core;
  logic [SLOT_WIDTH-1:0]    offer_slot;
  logic                     take;

  slot_write_if #(.CORE_ID_WIDTH(CORE_ID_WIDTH), .SLOT_WIDTH(SLOT_WIDTH)) wr_bus ();

  pool_view_if #(
    .CORE_COUNT(CORE_COUNT),
    .CORE_ID_WIDTH(CORE_ID_WIDTH),
    .SLOT_WIDTH(SLOT_WIDTH)
  ) view_bus ();

  ctrl_intake #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) intake_i (
    .wr(wr_bus),
    .*
  );

  slot_pool #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) pool_i (
    .wr(wr_bus),
    .view(view_bus),
    .*
  );

  core_select #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) select_i (
    .view(view_bus),
    .*
  );

  port_stamp #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT),
    .INTERFACE_COUNT(INTERFACE_COUNT)
  ) stamp_i (
    .*
  );

  // payload passes straight through
  assign data_m_data = rx_data;
  assign data_m_keep = rx_keep;
  assign data_m_last = rx_last;

endmodule

`default_nettype wire

// ==== verilog/sched_pkg.sv ====
`default_nettype none

package sched_pkg;

  // control message layout
  localparam int CTRL_WIDTH     = 36;
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int SLOT_FIELD_LSB = 16;

  typedef logic [MSG_TYPE_WIDTH-1:0] msg_type_t;
  typedef logic [CTRL_WIDTH-1:0]     ctrl_word_t;

  // message types that change the pools
  localparam msg_type_t MSG_PKT_SENT  = 4'd0;
  localparam msg_type_t MSG_SLOT_LOAD = 4'd3;

  // slot loader FSM
  typedef enum logic [1:0] {
    LOADER_IDLE,
    LOADER_CLEAR,
    LOADER_FILL
  } loader_state_t;

endpackage

`default_nettype wire

// ==== verilog/slot_pool.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_pool #(
  parameter int CORE_COUNT = 4,
  parameter int SLOT_COUNT = 4,
  localparam int CORE_ID_WIDTH = (CORE_COUNT > 1) ? $clog2(CORE_COUNT) : 1,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1)
) (
  input  logic                     clk,
  input  logic                     rst,
  slot_write_if.pool               wr,
  pool_view_if.pool                view,
  input  logic [CORE_ID_WIDTH-1:0] count_core,
  output logic [SLOT_WIDTH-1:0]    slot_count
);

  localparam int PTR_WIDTH = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;

  typedef logic [SLOT_WIDTH-1:0] slot_t;
  typedef logic [PTR_WIDTH-1:0]  ptr_t;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(SLOT_COUNT - 1)) ? '0 : p + 1'b1;
  endfunction

  assign wr.full    = (view.count[wr.core] == slot_t'(SLOT_COUNT));
  assign slot_count = view.count[count_core];

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_core
    slot_t mem [SLOT_COUNT];
    ptr_t  head_ptr;
    ptr_t  tail_ptr;
    slot_t occupancy;
    logic  ins;
    logic  pop;

    assign view.cleared[c] = wr.valid && wr.clear && (wr.core == CORE_ID_WIDTH'(c));
    assign ins = wr.valid && !wr.clear && (wr.core == CORE_ID_WIDTH'(c));
    assign pop = view.pop && (view.pop_core == CORE_ID_WIDTH'(c));

    assign view.count[c]    = occupancy;
    assign view.head[c]     = mem[head_ptr];
    assign view.nonempty[c] = (occupancy != '0);

    // a clear in the same cycle wins over the pop
    always_ff @(posedge clk) begin
      if (rst || view.cleared[c]) begin
        head_ptr  <= '0;
        tail_ptr  <= '0;
        occupancy <= '0;
      end else begin
        if (ins) begin
          tail_ptr <= next_ptr(tail_ptr);
        end
        if (pop) begin
          head_ptr <= next_ptr(head_ptr);
        end
        if (ins && !pop) begin
          occupancy <= occupancy + 1'b1;
        end else if (pop && !ins) begin
          occupancy <= occupancy - 1'b1;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (ins) begin
        mem[tail_ptr] <= wr.slot;
      end
    end

    no_overflow_a: assert property (@(posedge clk) disable iff (rst)
      ins |-> (occupancy != slot_t'(SLOT_COUNT)));
    no_underflow_a: assert property (@(posedge clk) disable iff (rst)
      (view.pop && (view.pop_core == CORE_ID_WIDTH'(c))) |-> (occupancy != '0));
  end

endmodule

`default_nettype wire

// ==== verilog/slot_write_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface slot_write_if #(
  parameter int CORE_ID_WIDTH = 2,
  parameter int SLOT_WIDTH    = 3
);

  logic                     valid;
  logic                     clear;
  logic [CORE_ID_WIDTH-1:0] core;
  logic [SLOT_WIDTH-1:0]    slot;
  // pool of the addressed core has no room
  logic                     full;

  modport intake (output valid, clear, core, slot, input full);
  modport pool (input valid, clear, core, slot, output full);

endinterface

`default_nettype wire
